//--- all.f
source/lsuPkg.sv
source/accessCheck.sv
source/reservationUnit.sv
source/storeAlign.sv
source/dtim.sv
source/loadAlign.sv
source/loadStoreUnit.sv
test/lsuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module lsuTb -f all.f

output=$(./obj_dir/VlsuTb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- test/lsuVectors.txt
# rw size atomic bigEndian flush address writeData | readData loadFault storeFault squash
# rw 1 store 2 load, size is funct3 (4 and 5 unsigned), atomic 1 LR 2 SC, all fields hex
1 2 0 0 0 000 12345678 00000000 0 0 0
2 2 0 0 0 000 00000000 12345678 0 0 0
1 0 0 0 0 010 000000a1 00000000 0 0 0
1 0 0 0 0 011 000000b2 00000000 0 0 0
1 1 0 0 0 012 0000c3d4 00000000 0 0 0
2 2 0 0 0 010 00000000 c3d4b2a1 0 0 0
1 1 0 0 0 020 00008091 00000000 0 0 0
1 0 0 0 0 022 0000007f 00000000 0 0 0
1 0 0 0 0 023 000000fe 00000000 0 0 0
2 2 0 0 0 020 00000000 fe7f8091 0 0 0
2 0 0 0 0 010 00000000 ffffffa1 0 0 0
2 4 0 0 0 011 00000000 000000b2 0 0 0
2 0 0 0 0 023 00000000 fffffffe 0 0 0
2 1 0 0 0 012 00000000 ffffc3d4 0 0 0
2 5 0 0 0 020 00000000 00008091 0 0 0
1 2 0 1 0 030 11223344 00000000 0 0 0
2 2 0 0 0 030 00000000 44332211 0 0 0
2 1 0 1 0 030 00000000 00001122 0 0 0
2 1 0 1 0 032 00000000 00003344 0 0 0
1 2 0 0 0 040 cafef00d 00000000 0 0 0
1 2 0 0 0 042 deadbeef 00000000 0 1 0
1 1 0 0 0 043 0000beef 00000000 0 1 0
2 1 0 0 0 041 00000000 00000000 1 0 0
2 2 0 0 0 042 00000000 00000000 1 0 0
1 2 0 0 0 050 55555555 00000000 0 0 0
2 2 1 0 0 050 00000000 55555555 0 0 0
1 2 2 0 0 050 66666666 00000000 0 0 0
1 2 2 0 0 050 77777777 00000000 0 0 1
2 2 1 0 0 050 00000000 66666666 0 0 0
1 2 2 0 0 040 88888888 00000000 0 0 1
2 2 0 0 0 040 00000000 cafef00d 0 0 0
1 2 0 0 0 060 aaaaaaaa 00000000 0 0 0
1 2 0 0 1 060 bbbbbbbb 00000000 0 0 0
2 2 0 0 0 060 00000000 aaaaaaaa 0 0 0

//--- test/lsuTb.sv
// LSU vector replay testbench
`default_nettype none

module lsuTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string       vectorFile   = "test/lsuVectors.txt";
  localparam int          resetCycles  = 2;
  localparam int          maxStallSlot = 2;                 // Stall cycles before one slot at most
  localparam logic [31:0] lcgSeed      = 32'd44705;

  // One access as read from the vector file, all zero for a bubble
  typedef struct packed {
    lsuPkg::memReqT          req;
    logic                    flush;                       // flushW while the access is in M
    logic [lsuPkg::xlen-1:0] addr;
    logic [lsuPkg::xlen-1:0] wdata;
    logic [lsuPkg::xlen-1:0] expRead;
    logic                    expLoadFault;
    logic                    expStoreFault;
    logic                    expSquash;
  } accessT;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    stall;
  logic                    flushW;
  logic [lsuPkg::xlen-1:0] ieuAdrE;
  lsuPkg::memReqT          reqM;
  logic [lsuPkg::xlen-1:0] writeDataM;
  logic [lsuPkg::xlen-1:0] ieuAdrM;
  logic [lsuPkg::xlen-1:0] readDataW;
  logic                    loadMisalignedFaultM;
  logic                    storeMisalignedFaultM;
  logic                    squashScW;

  accessT      schedule[$];                              // Vectors plus bubbles, one per slot
  int          vecCount   = 0;
  int          errorCount = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  logic [31:0] lcgState   = lcgSeed;

  loadStoreUnit u_dut (
    .clk, .reset, .stall, .flushW,
    .ieuAdrE, .reqM, .writeDataM,
    .ieuAdrM, .readDataW,
    .loadMisalignedFaultM, .storeMisalignedFaultM, .squashScW
  );

  always #20 clk = ~clk;                                  // 40 ns period

  // Run length guard
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, the replay did not finish", cycleCount);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic reportMismatch(input string name, input int idx,
                                input logic [31:0] got, input logic [31:0] exp);
    errorCount++;
    if (idx < 0) begin
      $display("FAIL %s after reset: got %h, expected %h", name, got, exp);
    end else begin
      $display("FAIL %s for access %0d: got %h, expected %h", name, idx, got, exp);
    end
  endtask

  //////////////////////////////
  // Vector file
  //////////////////////////////

  task automatic loadVectors();
    int          fd;
    int          fields;
    int          lineNum;
    string       line;
    logic [31:0] rw, size, atomic, be, flush, addr, wdata, expRead, lf, sf, sq;
    accessT      acc;
    fd = $fopen(vectorFile, "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open %s", vectorFile);
    end else begin
      lineNum = 0;
      while (!$feof(fd)) begin
        line = "";
        fields = $fgets(line, fd);
        lineNum++;
        if (line.len() > 1 && line.getc(0) != "#") begin   // Skip blanks and comments
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                           rw, size, atomic, be, flush, addr, wdata, expRead, lf, sf, sq);
          if (fields != 11) begin
            errorCount++;
            $display("Vector line %0d has %0d fields instead of 11", lineNum, fields);
          end else begin
            acc               = '0;
            acc.req.rw        = lsuPkg::memRwT'(rw[1:0]);
            acc.req.size      = lsuPkg::sizeT'(size[2:0]);
            acc.req.atomic    = lsuPkg::atomicT'(atomic[1:0]);
            acc.req.bigEndian = be[0];
            acc.flush         = flush[0];
            acc.addr          = addr;
            acc.wdata         = wdata;
            acc.expRead       = expRead;
            acc.expLoadFault  = lf[0];
            acc.expStoreFault = sf[0];
            acc.expSquash     = sq[0];
            schedule.push_back(acc);
            vecCount++;
            if (acc.req.rw == lsuPkg::rwWrite) schedule.push_back('0);  // Store owns the port
          end
        end
      end
      $fclose(fd);
    end
    schedule.push_back('0);                               // Drain M and W
    schedule.push_back('0);
  endtask

  //////////////////////////////
  // Replay
  //////////////////////////////

  // Slot N has access N in E, N-1 in M and N-2 in W
  task automatic runCycle(input int slot, input logic stallIn);
    accessT mAcc;
    accessT wAcc;
    mAcc = '0;
    wAcc = '0;
    if (slot >= 1) mAcc = schedule[slot-1];
    if (slot >= 2) wAcc = schedule[slot-2];
    @(posedge clk);
    #5;
    stall      = stallIn;                                 // Inputs repeat under stall
    ieuAdrE    = schedule[slot].addr;
    reqM       = mAcc.req;
    writeDataM = mAcc.wdata;
    flushW     = mAcc.flush;
    @(negedge clk);
    if (ieuAdrM !== mAcc.addr) reportMismatch("ieuAdrM", slot - 1, ieuAdrM, mAcc.addr);
    if (loadMisalignedFaultM !== mAcc.expLoadFault)
      reportMismatch("loadMisalignedFaultM", slot - 1,
                     32'(loadMisalignedFaultM), 32'(mAcc.expLoadFault));
    if (storeMisalignedFaultM !== mAcc.expStoreFault)
      reportMismatch("storeMisalignedFaultM", slot - 1,
                     32'(storeMisalignedFaultM), 32'(mAcc.expStoreFault));
    if (squashScW !== wAcc.expSquash)
      reportMismatch("squashScW", slot - 2, 32'(squashScW), 32'(wAcc.expSquash));
    // Only live loads carry a defined result
    if (wAcc.req.rw == lsuPkg::rwRead && !wAcc.expLoadFault && !wAcc.flush) begin
      if (readDataW !== wAcc.expRead) reportMismatch("readDataW", slot - 2, readDataW, wAcc.expRead);
    end
  endtask

  task automatic replaySchedule();
    int stallCycles;
    for (int slot = 0; slot < schedule.size(); slot++) begin
      stallCycles = 0;
      lcgState = nextRand(lcgState);
      if (lcgState[17:16] == 2'b00) stallCycles = lcgState[20] ? 2 : 1;
      if (slot >= 2) begin
        // Hold a squashed SC in W for at least one cycle
        if (schedule[slot-2].expSquash && stallCycles == 0) stallCycles = 1;
      end
      repeat (stallCycles) runCycle(slot, 1'b1);
      runCycle(slot, 1'b0);
    end
  endtask

  initial begin
    reset      = 1'b1;
    stall      = 1'b0;
    flushW     = 1'b0;
    ieuAdrE    = '0;
    reqM       = '0;
    writeDataM = '0;
    loadVectors();
    cycleLimit = 4 * vecCount + maxStallSlot * schedule.size() + resetCycles;
    if (vecCount == 0) begin
      errorCount++;
      $display("No vectors were loaded");
    end else begin
      repeat (resetCycles) @(posedge clk);
      #5;
      reset = 1'b0;
      @(negedge clk);
      if (ieuAdrM !== '0) reportMismatch("ieuAdrM", -1, ieuAdrM, '0);
      if (readDataW !== '0) reportMismatch("readDataW", -1, readDataW, '0);
      if (squashScW !== 1'b0) reportMismatch("squashScW", -1, 32'(squashScW), '0);
      replaySchedule();
    end
    $display("Vectors %0d, cycles %0d, errors %0d", vecCount, cycleCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/loadStoreUnit.sv
// Load/store unit top
`default_nettype none

module loadStoreUnit #(
  parameter int dtimWords = 256                      // DTIM depth in words, power of two
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,             // Freeze M and W
  input  logic                    flushW,            // Kill the access in M
  input  logic [lsuPkg::xlen-1:0] ieuAdrE,           // Execute-stage address
  input  lsuPkg::memReqT          reqM,              // Memory-stage controls
  input  logic [lsuPkg::xlen-1:0] writeDataM,        // Store data from IEU
  output logic [lsuPkg::xlen-1:0] ieuAdrM,           // Memory-stage address
  output logic [lsuPkg::xlen-1:0] readDataW,         // Load result to writeback
  output logic                    loadMisalignedFaultM,
  output logic                    storeMisalignedFaultM,
  output logic                    squashScW          // SC failed, suppress GPR write
);

  lsuPkg::memReqT          gatedReqM;                // Request after fault and flush gating
  lsuPkg::memRwT           memRwM;                   // Request after SC squash
  lsuPkg::storeWordT       storeWordM;               // Aligned store data and mask
  logic [lsuPkg::xlen-1:0] readWordM;                // Raw DTIM word

  //////////////////////////////
  // Address and request checks
  //////////////////////////////

  accessCheck check (
    .clk, .reset, .stall, .flushW,
    .ieuAdrE, .reqM,
    .ieuAdrM, .gatedReqM,
    .loadMisalignedFaultM, .storeMisalignedFaultM
  );

  // LR/SC reservation
  reservationUnit reservation (
    .clk, .reset, .stall,
    .ieuAdrM, .gatedReqM,
    .memRwM, .squashScW
  );

  //////////////////////////////
  // Data path
  //////////////////////////////

  storeAlign storePath (
    .ieuAdrM, .gatedReqM, .writeDataM,
    .storeWordM
  );

  dtim #(
    .dtimWords(dtimWords)
  ) memory (
    .clk, .stall,
    .ieuAdrE, .ieuAdrM,
    .memRwM, .storeWordM,
    .readWordM
  );

  loadAlign loadPath (
    .clk, .reset, .stall,
    .ieuAdrM, .gatedReqM, .readWordM,
    .readDataW
  );

endmodule

`default_nettype wire

//--- source/loadAlign.sv
// Load data extraction and writeback register
`default_nettype none

module loadAlign (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,             // Hold readDataW
  input  logic [lsuPkg::xlen-1:0] ieuAdrM,
  input  lsuPkg::memReqT          gatedReqM,
  input  logic [lsuPkg::xlen-1:0] readWordM,         // Raw word from the DTIM
  output logic [lsuPkg::xlen-1:0] readDataW
);

  logic [lsuPkg::xlen-1:0] wordM;                    // Word in little-endian order
  logic [1:0]              laneM;                    // Byte lane after endian correction
  logic [7:0]              byteM;
  logic [15:0]             halfM;
  logic [lsuPkg::xlen-1:0] readDataM;                // Extended load result

  assign wordM = gatedReqM.bigEndian ? lsuPkg::swapBytes(readWordM) : readWordM;

  // Swapping the word mirrors the lanes too
  assign laneM = ieuAdrM[1:0] ^ {2{gatedReqM.bigEndian}};
  assign byteM = wordM[8*laneM +: 8];
  assign halfM = wordM[16*laneM[1] +: 16];

  //////////////////////////////
  // Sign or zero extension
  //////////////////////////////

  always_comb begin
    case (gatedReqM.size.width)
      lsuPkg::widthByte: begin
        readDataM = {{(lsuPkg::xlen-8){byteM[7] & ~gatedReqM.size.unsignedLoad}}, byteM};
      end
      lsuPkg::widthHalf: begin
        readDataM = {{(lsuPkg::xlen-16){halfM[15] & ~gatedReqM.size.unsignedLoad}}, halfM};
      end
      default: begin
        readDataM = wordM;                           // LW and LR
      end
    endcase
  end

  // M to W read-data register
  always_ff @(posedge clk) begin
    if (reset) begin
      readDataW <= '0;
    end else if (!stall) begin
      readDataW <= readDataM;
    end
  end

endmodule

`default_nettype wire

//--- source/dtim.sv
// Data tightly integrated memory
`default_nettype none

module dtim #(
  parameter int dtimWords = 256                      // Depth in words
) (
  input  logic                    clk,
  input  logic                    stall,             // Hold read register and block writes
  input  logic [lsuPkg::xlen-1:0] ieuAdrE,           // Read address
  input  logic [lsuPkg::xlen-1:0] ieuAdrM,           // Write address
  input  lsuPkg::memRwT           memRwM,
  input  lsuPkg::storeWordT       storeWordM,
  output logic [lsuPkg::xlen-1:0] readWordM          // Word read in E, valid in M
);

  localparam int offsetBits = $clog2(lsuPkg::xlenBytes);
  localparam int adrBits    = $clog2(dtimWords);

  logic [lsuPkg::xlenBytes-1:0][7:0] mem [dtimWords];   // Byte-addressable storage
  logic [adrBits-1:0]                dtimAdr;            // Shared port address
  logic                              writeM;

  assign writeM = (memRwM == lsuPkg::rwWrite);

  // Single port, a store in M takes it from the next E
  assign dtimAdr = writeM ? ieuAdrM[adrBits+offsetBits-1:offsetBits]
                          : ieuAdrE[adrBits+offsetBits-1:offsetBits];

  //////////////////////////////
  // Memory array
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!stall) begin
      if (writeM) begin
        for (int i = 0; i < lsuPkg::xlenBytes; i++) begin
          if (storeWordM.byteMask[i]) begin
            mem[dtimAdr][i] <= storeWordM.data[8*i +: 8];
          end
        end
      end
      readWordM <= mem[dtimAdr];                     // Old data on a write cycle
    end
  end

  // storeAlign always enables at least one lane for a live write
  writeHasLanes: assert property (@(posedge clk)
    (!stall && writeM) |-> (|storeWordM.byteMask));

endmodule

`default_nettype wire

//--- source/storeAlign.sv
// Store data lane alignment
`default_nettype none

module storeAlign (
  input  logic [lsuPkg::xlen-1:0] ieuAdrM,
  input  lsuPkg::memReqT          gatedReqM,
  input  logic [lsuPkg::xlen-1:0] writeDataM,        // Little-endian store data
  output lsuPkg::storeWordT       storeWordM         // Word and byte enables for the DTIM
);

  localparam logic [lsuPkg::xlenBytes-1:0] byteLanes = 1;   // One lane enabled
  localparam logic [lsuPkg::xlenBytes-1:0] halfLanes = 3;   // Two lanes enabled

  logic [lsuPkg::xlen-1:0]      replicatedM;         // Subword copied to every lane
  logic [lsuPkg::xlenBytes-1:0] byteMaskM;

  // Replicate and mask by access width
  always_comb begin
    case (gatedReqM.size.width)
      lsuPkg::widthByte: begin
        replicatedM = {lsuPkg::xlenBytes{writeDataM[7:0]}};
        byteMaskM   = byteLanes << ieuAdrM[1:0];
      end
      lsuPkg::widthHalf: begin
        replicatedM = {(lsuPkg::xlenBytes / 2){writeDataM[15:0]}};
        byteMaskM   = halfLanes << {ieuAdrM[1], 1'b0};
      end
      default: begin
        replicatedM = writeDataM;                    // Full word
        byteMaskM   = '1;
      end
    endcase
  end

  // Swap after replication so the mask still follows the address
  always_comb begin
    storeWordM.byteMask = byteMaskM;
    if (gatedReqM.bigEndian) begin
      storeWordM.data = lsuPkg::swapBytes(replicatedM);
    end else begin
      storeWordM.data = replicatedM;
    end
  end

endmodule

`default_nettype wire

//--- source/reservationUnit.sv
// LR/SC reservation tracking
`default_nettype none

module reservationUnit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,             // Hold reservation and squash flag
  input  logic [lsuPkg::xlen-1:0] ieuAdrM,
  input  lsuPkg::memReqT          gatedReqM,
  output lsuPkg::memRwT           memRwM,            // Request to the DTIM
  output logic                    squashScW          // Registered SC failure
);

  localparam int offsetBits = $clog2(lsuPkg::xlenBytes);

  logic                               resValid;      // Reservation held
  logic [lsuPkg::xlen-1:offsetBits]   resAdr;        // Reserved word address
  logic [lsuPkg::xlen-1:offsetBits]   wordAdrM;
  logic                               isLrM;
  logic                               isScM;
  logic                               scFailM;       // SC without a matching reservation

  assign wordAdrM = ieuAdrM[lsuPkg::xlen-1:offsetBits];
  assign isLrM    = (gatedReqM.atomic == lsuPkg::atomicLr) & (gatedReqM.rw == lsuPkg::rwRead);
  assign isScM    = (gatedReqM.atomic == lsuPkg::atomicSc) & (gatedReqM.rw == lsuPkg::rwWrite);
  assign scFailM  = isScM & ~(resValid & (resAdr == wordAdrM));

  // Failed SC loses its write
  assign memRwM = scFailM ? lsuPkg::rwNone : gatedReqM.rw;

  //////////////////////////////
  // Reservation state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      resValid  <= 1'b0;
      squashScW <= 1'b0;
    end else if (!stall) begin
      squashScW <= scFailM;                          // Valid alongside readDataW
      if (isLrM) begin
        resValid <= 1'b1;
      end else if (isScM) begin
        resValid <= 1'b0;                            // Any SC ends the reservation
      end
    end
  end

  // Word address of the last LR
  always_ff @(posedge clk) begin
    if (!stall && isLrM) begin
      resAdr <= wordAdrM;
    end
  end

  // The reservation covers one word, so LR and SC are word accesses
  wordSizedAtomic: assert property (@(posedge clk) disable iff (reset)
    (isLrM || isScM) |-> (gatedReqM.size.width == lsuPkg::widthWord));

endmodule

`default_nettype wire

//--- source/accessCheck.sv
// Address pipeline and alignment check
`default_nettype none

module accessCheck (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,             // Hold the M address
  input  logic                    flushW,            // Discard the access in M
  input  logic [lsuPkg::xlen-1:0] ieuAdrE,
  input  lsuPkg::memReqT          reqM,
  output logic [lsuPkg::xlen-1:0] ieuAdrM,
  output lsuPkg::memReqT          gatedReqM,         // Safe request for the rest of the LSU
  output logic                    loadMisalignedFaultM,
  output logic                    storeMisalignedFaultM
);

  logic misalignedM;                                 // Address not a multiple of the size
  logic faultM;                                      // Either misalignment fault

  // E to M address register
  always_ff @(posedge clk) begin
    if (reset) begin
      ieuAdrM <= '0;
    end else if (!stall) begin
      ieuAdrM <= ieuAdrE;
    end
  end

  // Natural alignment by access width
  always_comb begin
    case (reqM.size.width)
      lsuPkg::widthHalf: misalignedM = ieuAdrM[0];
      lsuPkg::widthWord: misalignedM = |ieuAdrM[1:0];
      default:           misalignedM = 1'b0;      // Bytes are always aligned
    endcase
  end

  assign loadMisalignedFaultM  = misalignedM & (reqM.rw == lsuPkg::rwRead);
  // SC reports as a store
  assign storeMisalignedFaultM = misalignedM &
                                 ((reqM.rw == lsuPkg::rwWrite) |
                                  (reqM.atomic == lsuPkg::atomicSc));
  assign faultM = loadMisalignedFaultM | storeMisalignedFaultM;

  // Drop the access on a fault or a writeback flush
  always_comb begin
    gatedReqM = reqM;
    if (faultM | flushW) begin
      gatedReqM.rw     = lsuPkg::rwNone;
      gatedReqM.atomic = lsuPkg::atomicNone;        // Keeps LR/SC from touching the reservation
    end
  end

  // An SC arrives as a write, so it never raises both faults
  scIsWrite: assert property (@(posedge clk) disable iff (reset)
    (reqM.atomic == lsuPkg::atomicSc) |-> (reqM.rw == lsuPkg::rwWrite));

endmodule

`default_nettype wire

//--- source/lsuPkg.sv
// LSU shared definitions
`default_nettype none

package lsuPkg;

  localparam int xlen      = 32;            // Data and address width
  localparam int xlenBytes = xlen / 8;      // Byte lanes per word

  // Request type, same bit positions as the core's MemRW
  typedef enum logic [1:0] {
    rwNone  = 2'b00,
    rwWrite = 2'b01,                        // Bit 0 marks a write
    rwRead  = 2'b10                         // Bit 1 marks a read
  } memRwT;

  // Access width in funct3[1:0]
  typedef enum logic [1:0] {
    widthByte = 2'b00,
    widthHalf = 2'b01,
    widthWord = 2'b10
  } widthT;

  // funct3 size code
  typedef struct packed {
    logic  unsignedLoad;                    // funct3[2], zero-extend on load
    widthT width;
  } sizeT;

  typedef enum logic [1:0] {
    atomicNone = 2'b00,
    atomicLr   = 2'b01,                     // Load-reserved
    atomicSc   = 2'b10                      // Store-conditional
  } atomicT;

  // Memory-stage controls, 8 bits
  typedef struct packed {
    memRwT  rw;
    sizeT   size;
    atomicT atomic;
    logic   bigEndian;                      // Per-access byte order
  } memReqT;

  // Word as presented to the DTIM write port
  typedef struct packed {
    logic [xlen-1:0]      data;
    logic [xlenBytes-1:0] byteMask;
  } storeWordT;

  // Reverse byte order of a word
  function automatic logic [xlen-1:0] swapBytes(input logic [xlen-1:0] word);
    logic [xlen-1:0] swapped;
    for (int i = 0; i < xlenBytes; i++) begin
      swapped[8*i +: 8] = word[8*(xlenBytes-1-i) +: 8];
    end
    return swapped;
  endfunction

endpackage

`default_nettype wire
